// ==== acDatapathPkg.sv ====
`default_nettype none

package acDatapathPkg;

    // byte width of every register and operand
    localparam int dataWidth = 8;

    // bcd thresholds, low digit and whole byte
    localparam logic [3:0] bcdLowLimit = 4'd9;
    localparam logic [dataWidth-1:0] bcdHighLimit = 8'h99;
    // bcd correction amounts
    localparam logic [dataWidth-1:0] bcdLowFix = 8'h06;
    localparam logic [dataWidth-1:0] bcdHighFix = 8'h60;

    // only the unused bit 5 is set after reset
    localparam logic [dataWidth-1:0] statusReset = 8'h20;

    // alu operation field of a command
    typedef enum logic [2:0] {
        opAdd, opSub, opAnd, opOr,
        opEor, opShr, opLoad, opFlag
    } aluOpT;

    // register select, selNone reads as zero and writes nothing
    typedef enum logic [1:0] {
        selAcc, selX, selY, selNone
    } regSelT;

    // explicit flag commands, only looked at for opFlag
    typedef enum logic [2:0] {
        flagNone, setC, clrC, setD,
        clrD, setI, clrI, clrV
    } flagOpT;

    // one command as strobed in from outside
    typedef struct packed {
        aluOpT  op;
        regSelT srcA;
        regSelT dest;
        logic   rotate;
        flagOpT flagOp;
    } cmdT;

    // processor status, NV1BDIZC from bit 7 down
    typedef struct packed {
        logic n;
        logic v;
        logic one;
        logic b;
        logic d;
        logic i;
        logic z;
        logic c;
    } statusT;

    // latched command with its operands
    typedef struct packed {
        cmdT                  cmd;
        logic [dataWidth-1:0] operandA;
        logic [dataWidth-1:0] operandB;
        logic                 carryIn;
        logic                 decimal;
    } opStageT;

    // adder hold register contents
    typedef struct packed {
        cmdT                  cmd;
        logic [dataWidth-1:0] sum;
        logic                 acr;
        logic                 avr;
        logic                 hc;
        logic                 decimal;
        logic                 carryIn;
    } holdT;

    // final value and flags for writeback
    typedef struct packed {
        cmdT                  cmd;
        logic [dataWidth-1:0] value;
        logic                 carry;
        logic                 overflow;
    } wbT;

endpackage

`default_nettype wire

// ==== operandLatch.sv ====
`default_nettype none

module operandLatch (
    input  wire                                    phi2,
    input  wire                                    rstAll,
    input  wire                                    haltAll,
    input  wire                                    cmdValid,
    input  wire acDatapathPkg::cmdT                cmd,
    input  wire [acDatapathPkg::dataWidth-1:0]     dataIn,
    input  wire [acDatapathPkg::dataWidth-1:0]     accumVal,
    input  wire [acDatapathPkg::dataWidth-1:0]     xVal,
    input  wire [acDatapathPkg::dataWidth-1:0]     yVal,
    input  wire acDatapathPkg::statusT             status,
    output acDatapathPkg::opStageT                 opStage,
    output logic                                   stageValid
);

    logic [acDatapathPkg::dataWidth-1:0] srcVal;
    logic [acDatapathPkg::dataWidth-1:0] dataVal;
    logic                                carrySel;

    // a-side source mux, selNone gives zero
    always_comb begin
        case (cmd.srcA)
            acDatapathPkg::selAcc: srcVal = accumVal;
            acDatapathPkg::selX:   srcVal = xVal;
            acDatapathPkg::selY:   srcVal = yVal;
            default:               srcVal = '0;
        endcase
    end

    // subtract adds the one's complement, borrow rides on carry
    assign dataVal = (cmd.op == acDatapathPkg::opSub) ? ~dataIn : dataIn;

    // carry-in choice
    always_comb begin
        case (cmd.op)
            acDatapathPkg::opAdd,
            acDatapathPkg::opSub: carrySel = status.c;
            // plain shift brings in a zero
            acDatapathPkg::opShr: carrySel = cmd.rotate & status.c;
            default:              carrySel = 1'b0;
        endcase
    end

    // stage valid flag
    always_ff @(posedge phi2) begin
        if (rstAll) begin
            stageValid <= 1'b0;
        end else if (!haltAll) begin
            stageValid <= cmdValid;
        end
    end

    // operands sampled at acceptance
    always_ff @(posedge phi2) begin
        if (!haltAll && cmdValid) begin
            opStage.cmd      <= cmd;
            opStage.operandA <= srcVal;
            opStage.operandB <= dataVal;
            opStage.carryIn  <= carrySel;
            // D flag as seen at acceptance
            opStage.decimal  <= status.d;
        end
    end

endmodule

`default_nettype wire

// ==== aluCore.sv ====
`default_nettype none

module aluCore (
    input  wire                         phi2,
    input  wire                         rstAll,
    input  wire                         haltAll,
    input  wire acDatapathPkg::opStageT opStage,
    input  wire                         stageValid,
    output acDatapathPkg::holdT         hold,
    output logic                        holdValid
);

    logic [acDatapathPkg::dataWidth:0]   sumFull;
    logic [4:0]                          lowSum;
    logic [acDatapathPkg::dataWidth-1:0] aluOut;
    logic                                acrNext;
    logic                                avrNext;
    logic                                sumOverflow;

    // 9-bit adder, carry out in the top bit
    assign sumFull = {1'b0, opStage.operandA} + {1'b0, opStage.operandB}
                   + {{acDatapathPkg::dataWidth{1'b0}}, opStage.carryIn};

    // low nibble with carry-in, for the half carry
    assign lowSum = {1'b0, opStage.operandA[3:0]} + {1'b0, opStage.operandB[3:0]}
                  + {4'b0, opStage.carryIn};

    // like signs in, other sign out
    assign sumOverflow = (opStage.operandA[7] == opStage.operandB[7])
                       && (opStage.operandA[7] != sumFull[7]);

    always_comb begin
        acrNext = 1'b0;
        avrNext = 1'b0;
        case (opStage.cmd.op)
            acDatapathPkg::opAdd,
            acDatapathPkg::opSub: begin
                aluOut  = sumFull[acDatapathPkg::dataWidth-1:0];
                acrNext = sumFull[acDatapathPkg::dataWidth];
                avrNext = sumOverflow;
            end
            acDatapathPkg::opAnd: aluOut = opStage.operandA & opStage.operandB;
            acDatapathPkg::opOr:  aluOut = opStage.operandA | opStage.operandB;
            acDatapathPkg::opEor: aluOut = opStage.operandA ^ opStage.operandB;
            acDatapathPkg::opShr: begin
                // carry-in enters at the top, bit 0 falls out
                aluOut  = {opStage.carryIn, opStage.operandB[7:1]};
                acrNext = opStage.operandB[0];
            end
            // load and flag-only pass the data byte
            default: aluOut = opStage.operandB;
        endcase
    end

    // hold valid flag
    always_ff @(posedge phi2) begin
        if (rstAll) begin
            holdValid <= 1'b0;
        end else if (!haltAll) begin
            holdValid <= stageValid;
        end
    end

    // adder hold register with raw flags
    always_ff @(posedge phi2) begin
        if (!haltAll && stageValid) begin
            hold.cmd     <= opStage.cmd;
            hold.sum     <= aluOut;
            hold.acr     <= acrNext;
            hold.avr     <= avrNext;
            hold.hc      <= lowSum[4];
            hold.decimal <= opStage.decimal;
            hold.carryIn <= opStage.carryIn;
        end
    end

endmodule

`default_nettype wire

// ==== decimalAdjust.sv ====
`default_nettype none

module decimalAdjust (
    input  wire acDatapathPkg::holdT hold,
    output acDatapathPkg::wbT        wb
);

    logic [acDatapathPkg::dataWidth-1:0] adjVal;
    logic                                adjCarry;
    logic                                decAdd;
    logic                                decSub;

    // correction only in decimal mode
    assign decAdd = hold.decimal && (hold.cmd.op == acDatapathPkg::opAdd);
    assign decSub = hold.decimal && (hold.cmd.op == acDatapathPkg::opSub);

    always_comb begin
        adjVal   = hold.sum;
        adjCarry = hold.acr;
        if (decAdd) begin
            // low digit past nine or nibble carried
            if ((hold.sum[3:0] > acDatapathPkg::bcdLowLimit) || hold.hc) begin
                adjVal = adjVal + acDatapathPkg::bcdLowFix;
            end
            // high digit, tested on the binary sum
            if (hold.acr || (hold.sum > acDatapathPkg::bcdHighLimit)) begin
                adjVal   = adjVal + acDatapathPkg::bcdHighFix;
                adjCarry = 1'b1;
            end else begin
                adjCarry = 1'b0;
            end
        end else if (decSub) begin
            // no half carry means the low digit borrowed
            if (!hold.hc) begin
                adjVal = adjVal - acDatapathPkg::bcdLowFix;
            end
            // same for the high digit, carry stays binary
            if (!hold.acr) begin
                adjVal = adjVal - acDatapathPkg::bcdHighFix;
            end
        end
    end

    // everything else passes through
    always_comb begin
        wb.cmd      = hold.cmd;
        wb.value    = adjVal;
        wb.carry    = adjCarry;
        wb.overflow = hold.avr;
    end

endmodule

`default_nettype wire

// ==== regWriteback.sv ====
`default_nettype none

module regWriteback (
    input  wire                                phi2,
    input  wire                                rstAll,
    input  wire                                haltAll,
    input  wire acDatapathPkg::wbT             wb,
    input  wire                                holdValid,
    output logic [acDatapathPkg::dataWidth-1:0] accumVal,
    output logic [acDatapathPkg::dataWidth-1:0] xVal,
    output logic [acDatapathPkg::dataWidth-1:0] yVal,
    output acDatapathPkg::statusT              status,
    output logic [acDatapathPkg::dataWidth-1:0] result,
    output logic                               resultValid
);

    acDatapathPkg::statusT nextStatus;
    logic                  valueZero;
    logic                  regWrite;

    // Z and N always from the adjusted value
    assign valueZero = (wb.value == '0);

    // flag-only commands never touch a register
    assign regWrite = holdValid && (wb.cmd.op != acDatapathPkg::opFlag);

    always_comb begin
        nextStatus = status;
        case (wb.cmd.op)
            acDatapathPkg::opAdd,
            acDatapathPkg::opSub,
            acDatapathPkg::opShr: begin
                nextStatus.n = wb.value[7];
                nextStatus.z = valueZero;
                nextStatus.c = wb.carry;
                nextStatus.v = wb.overflow;
            end
            acDatapathPkg::opFlag: begin
                case (wb.cmd.flagOp)
                    acDatapathPkg::setC: nextStatus.c = 1'b1;
                    acDatapathPkg::clrC: nextStatus.c = 1'b0;
                    acDatapathPkg::setD: nextStatus.d = 1'b1;
                    acDatapathPkg::clrD: nextStatus.d = 1'b0;
                    acDatapathPkg::setI: nextStatus.i = 1'b1;
                    acDatapathPkg::clrI: nextStatus.i = 1'b0;
                    acDatapathPkg::clrV: nextStatus.v = 1'b0;
                    default:             nextStatus = status;
                endcase
            end
            // logic ops and loads, C and V kept
            default: begin
                nextStatus.n = wb.value[7];
                nextStatus.z = valueZero;
            end
        endcase
        // fixed bits
        nextStatus.one = 1'b1;
        nextStatus.b   = 1'b0;
    end

    always_ff @(posedge phi2) begin
        if (rstAll) begin
            accumVal    <= '0;
            xVal        <= '0;
            yVal        <= '0;
            status      <= acDatapathPkg::statusT'(acDatapathPkg::statusReset);
            result      <= '0;
            resultValid <= 1'b0;
        end else if (!haltAll) begin
            // one pulse per command leaving the pipe
            resultValid <= holdValid;
            if (holdValid) begin
                result <= wb.value;
                status <= nextStatus;
            end
            if (regWrite) begin
                case (wb.cmd.dest)
                    acDatapathPkg::selAcc: accumVal <= wb.value;
                    acDatapathPkg::selX:   xVal     <= wb.value;
                    acDatapathPkg::selY:   yVal     <= wb.value;
                    // compare style, flags only
                    default:               accumVal <= accumVal;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== acDatapath.sv ====
`default_nettype none

module acDatapath (
    input  wire                                 phi2,
    input  wire                                 rstAll,
    input  wire                                 haltAll,
    input  wire                                 cmdValid,
    input  wire acDatapathPkg::cmdT             cmd,
    input  wire [acDatapathPkg::dataWidth-1:0]  dataIn,
    output logic [acDatapathPkg::dataWidth-1:0] accumVal,
    output logic [acDatapathPkg::dataWidth-1:0] xVal,
    output logic [acDatapathPkg::dataWidth-1:0] yVal,
    output acDatapathPkg::statusT               status,
    output logic [acDatapathPkg::dataWidth-1:0] result,
    output logic                                resultValid
);

    // stage 1, latched command and operands
    acDatapathPkg::opStageT opStage;
    logic                   stageValid;
    // stage 2, adder hold
    acDatapathPkg::holdT    hold;
    logic                   holdValid;
    // adjusted value into writeback
    acDatapathPkg::wbT      wb;

    operandLatch uOperandLatch (
        .phi2       (phi2),
        .rstAll     (rstAll),
        .haltAll    (haltAll),
        .cmdValid   (cmdValid),
        .cmd        (cmd),
        .dataIn     (dataIn),
        .accumVal   (accumVal),
        .xVal       (xVal),
        .yVal       (yVal),
        .status     (status),
        .opStage    (opStage),
        .stageValid (stageValid)
    );

    aluCore uAluCore (
        .phi2       (phi2),
        .rstAll     (rstAll),
        .haltAll    (haltAll),
        .opStage    (opStage),
        .stageValid (stageValid),
        .hold       (hold),
        .holdValid  (holdValid)
    );

    // combinational, between hold and writeback
    decimalAdjust uDecimalAdjust (
        .hold (hold),
        .wb   (wb)
    );

    regWriteback uRegWriteback (
        .phi2        (phi2),
        .rstAll      (rstAll),
        .haltAll     (haltAll),
        .wb          (wb),
        .holdValid   (holdValid),
        .accumVal    (accumVal),
        .xVal        (xVal),
        .yVal        (yVal),
        .status      (status),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

`default_nettype wire

// ==== acDatapath_chk.sv ====
`default_nettype none

module acDatapath_chk (
    input wire       phi2,
    input wire       rstAll,
    input wire       haltAll,
    input wire       cmdValid,
    input wire [7:0] accumVal,
    input wire [7:0] xVal,
    input wire [7:0] yVal,
    input wire acDatapathPkg::statusT status,
    input wire [7:0] result,
    input wire       resultValid
);

    timeunit 1ns;
    timeprecision 1ns;

    // accepted strobes move along on unhalted edges only
    logic [2:0] validTrack;

    always_ff @(posedge phi2) begin
        if (rstAll) begin
            validTrack <= '0;
        end else if (!haltAll) begin
            validTrack <= {validTrack[1:0], cmdValid};
        end
    end

    resultFollowsCmd: assert property (@(posedge phi2) disable iff (rstAll)
        resultValid == validTrack[2])
        else $error("resultValid out of step with accepted commands");

    // one pulse per command
    resultPulse: assert property (@(posedge phi2) disable iff (rstAll)
        resultValid && !haltAll |=> !resultValid)
        else $error("resultValid high for two unhalted cycles");

    statusOne: assert property (@(posedge phi2) disable iff (rstAll)
        status.one)
        else $error("status bit 5 dropped");

    // nothing moves while frozen
    haltFreeze: assert property (@(posedge phi2) disable iff (rstAll)
        haltAll |=> $stable({accumVal, xVal, yVal, status, result, resultValid}))
        else $error("outputs changed during haltAll");

endmodule

`default_nettype wire

// ==== acDatapath_tb.sv ====
`default_nettype none

module acDatapath_tb;

    timeunit 1ns;
    timeprecision 1ns;

    // words on one golden line
    localparam int lineWords = 13;
    localparam int maxCmds = 64;
    // slack on top of the golden schedule
    localparam int marginCycles = 20;
    localparam int resetCycles = 3;

    logic phi2 = 1'b0;
    logic rstAll;
    logic haltAll;
    logic cmdValid;
    acDatapathPkg::cmdT cmd;
    logic [acDatapathPkg::dataWidth-1:0] dataIn;
    logic [acDatapathPkg::dataWidth-1:0] accumVal;
    logic [acDatapathPkg::dataWidth-1:0] xVal;
    logic [acDatapathPkg::dataWidth-1:0] yVal;
    acDatapathPkg::statusT status;
    logic [acDatapathPkg::dataWidth-1:0] result;
    logic resultValid;

    // word 0 is the command count, then one line per command
    logic [7:0] golden [0:lineWords*maxCmds];
    int cmdCount;
    int cycleCount = 0;
    int cycleLimit = 0;

    acDatapath DUT (
        .phi2        (phi2),
        .rstAll      (rstAll),
        .haltAll     (haltAll),
        .cmdValid    (cmdValid),
        .cmd         (cmd),
        .dataIn      (dataIn),
        .accumVal    (accumVal),
        .xVal        (xVal),
        .yVal        (yVal),
        .status      (status),
        .result      (result),
        .resultValid (resultValid)
    );

    bind acDatapath acDatapath_chk uChk (
        .phi2        (phi2),
        .rstAll      (rstAll),
        .haltAll     (haltAll),
        .cmdValid    (cmdValid),
        .accumVal    (accumVal),
        .xVal        (xVal),
        .yVal        (yVal),
        .status      (status),
        .result      (result),
        .resultValid (resultValid)
    );

    // 20 ns period
    always #10 phi2 = ~phi2;

    // run limit from the golden schedule
    always @(posedge phi2) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("run went past the limit of %0d cycles without finishing", cycleLimit);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    task automatic checkByte(input string what, input logic [7:0] got, input logic [7:0] exp);
        assert (got == exp) else begin
            $display("Mismatch at %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic runCommand(input int idx);
        int base;
        int idle;
        int halt;
        int waited;
        base = 1 + idx * lineWords;
        idle = int'(golden[base + 6]);
        halt = int'(golden[base + 7]);
        // strobe on the falling edge
        @(negedge phi2);
        cmd.op     = acDatapathPkg::aluOpT'(golden[base][2:0]);
        cmd.srcA   = acDatapathPkg::regSelT'(golden[base + 1][1:0]);
        cmd.dest   = acDatapathPkg::regSelT'(golden[base + 2][1:0]);
        cmd.rotate = golden[base + 3][0];
        cmd.flagOp = acDatapathPkg::flagOpT'(golden[base + 4][2:0]);
        dataIn     = golden[base + 5];
        cmdValid   = 1'b1;
        @(negedge phi2);
        cmdValid = 1'b0;
        waited = 1;
        // freeze right behind the command
        if (halt > 0) begin
            haltAll = 1'b1;
            repeat (halt) @(negedge phi2);
            haltAll = 1'b0;
            waited += halt;
        end
        while (!resultValid) begin
            @(negedge phi2);
            waited++;
        end
        // two stages after acceptance plus the frozen cycles
        assert (waited == 3 + halt) else begin
            $display("Mismatch at %0t ns: cmd %0d result after %0d cycles, expected %0d",
                     $time, idx, waited, 3 + halt);
            $display("test failed");
            $fatal(1, "latency check failed");
        end
        checkByte($sformatf("cmd %0d result", idx), result, golden[base + 8]);
        checkByte($sformatf("cmd %0d accumVal", idx), accumVal, golden[base + 9]);
        checkByte($sformatf("cmd %0d xVal", idx), xVal, golden[base + 10]);
        checkByte($sformatf("cmd %0d yVal", idx), yVal, golden[base + 11]);
        checkByte($sformatf("cmd %0d status", idx), status, golden[base + 12]);
        repeat (idle) @(negedge phi2);
    endtask

    initial begin
        rstAll   = 1'b1;
        haltAll  = 1'b0;
        cmdValid = 1'b0;
        cmd      = '0;
        dataIn   = '0;
        $readmemh("acDatapath_golden.txt", golden);
        cmdCount = int'(golden[0]);
        if (cmdCount == 0 || cmdCount > maxCmds) begin
            $display("golden file holds an unusable command count of %0d", cmdCount);
            $display("test failed");
            $fatal(1, "bad golden file");
        end
        // reset, drive, three stages, halt and idle per command
        cycleLimit = resetCycles + marginCycles;
        for (int i = 0; i < cmdCount; i++) begin
            cycleLimit += 4 + int'(golden[1 + i * lineWords + 6])
                        + int'(golden[1 + i * lineWords + 7]);
        end
        repeat (resetCycles) @(negedge phi2);
        rstAll = 1'b0;
        // reset state
        checkByte("accumVal after reset", accumVal, 8'h00);
        checkByte("xVal after reset", xVal, 8'h00);
        checkByte("yVal after reset", yVal, 8'h00);
        // only bit 5 set out of reset
        checkByte("status after reset", status, 8'h20);
        checkByte("resultValid after reset", {7'b0, resultValid}, 8'h00);
        for (int i = 0; i < cmdCount; i++) begin
            runCommand(i);
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== acDatapath_golden.txt ====
// number of commands, then per line: op srcA dest rotate flagOp data idle halt
// followed by expected result accumVal xVal yVal status
1e
00 03 00 00 00 50 00 00 50 50 00 00 20
00 00 00 00 00 50 00 00 a0 a0 00 00 e0
00 00 00 00 00 70 01 00 10 10 00 00 21
01 00 00 00 00 10 00 00 00 00 00 00 23
07 03 03 00 02 00 00 00 00 00 00 00 22
01 00 00 00 00 01 00 00 fe fe 00 00 a0
07 03 03 00 01 00 00 00 00 fe 00 00 a1
06 03 01 00 00 80 00 00 80 fe 80 00 a1
01 01 02 00 00 01 02 00 7f fe 80 7f 61
02 02 00 00 00 0f 00 00 0f 0f 80 7f 61
03 00 01 00 00 f0 00 00 ff 0f ff 7f e1
04 01 02 00 00 ff 00 00 00 0f ff 00 63
06 03 00 00 00 81 00 00 81 81 ff 00 e1
07 03 03 00 07 00 00 00 00 81 ff 00 a1
05 03 00 00 00 81 00 00 40 40 ff 00 21
05 03 01 01 00 02 00 00 81 40 81 00 a0
05 03 02 01 00 01 00 00 00 40 81 00 23
01 00 03 00 00 50 01 00 f0 40 81 00 a0
07 03 03 00 05 00 00 00 00 40 81 00 a4
07 03 03 00 06 00 00 00 00 40 81 00 a0
07 03 03 00 03 00 00 00 00 40 81 00 a8
06 03 00 00 00 19 00 00 19 19 81 00 28
00 00 00 00 00 28 00 00 47 47 81 00 28
00 00 00 00 00 58 00 00 05 05 81 00 69
01 00 00 00 00 06 00 00 99 99 81 00 a8
07 03 03 00 01 00 00 00 00 99 81 00 a9
01 00 00 00 00 45 00 00 54 54 81 00 69
07 03 03 00 04 00 02 00 00 54 81 00 61
00 00 00 00 00 01 00 04 56 56 81 00 20
06 03 01 00 00 00 01 02 00 56 00 00 22

// ==== acDatapath.f ====
acDatapathPkg.sv
operandLatch.sv
aluCore.sv
decimalAdjust.sv
regWriteback.sv
acDatapath.sv
acDatapath_chk.sv
acDatapath_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= acDatapath_tb
FILELIST  ?= acDatapath.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
